// ==== sim.f ====
+incdir+hw
hw/isa_pkg.sv
hw/frontend_pkg.sv
hw/branch_target_table.sv
hw/fetch_pc_gen.sv
hw/fetch_queue.sv
hw/if2_predecoder.sv
hw/frontend_top.sv
tests/frontend_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    -f sim.f --top-module frontend_tb -o frontend_sim

# The log decides pass or fail
./obj_dir/frontend_sim > sim.log 2>&1 || true
cat sim.log

if grep -qx "PASS: all tests" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// ==== tests/frontend_tb.sv ====
`include "frontend_settings.svh"

module frontend_tb;

    localparam int PACKETS        = 200;
    // About 12 cycles per packet covers redirects and stalls
    localparam int TIMEOUT_CYCLES = PACKETS * 12;
    localparam int READY_PERCENT  = 70;

    // Learned prediction per program word
    typedef struct packed {
        logic              valid;
        isa_pkg::br_kind_e kind;
        isa_pkg::addr_t    target;
    } pred_entry_t;

    logic                   clk;
    logic                   rst;
    isa_pkg::addr_t         imem_addr;
    isa_pkg::inst_t         imem_data;
    logic                   dec_valid;
    logic                   dec_ready;
    frontend_pkg::dec_pkt_t dec_pkt;
    logic                   redirect_valid;

    // Reference path state
    frontend_pkg::dec_pkt_t exp_pkt;
    pred_entry_t            pred_table [64];
    logic                   first_pending;
    int                     accepted = 0;
    // Redirects per program word over the whole run
    int                     redirect_count [64] = '{default: 0};
    int                     redirect_total = 0;
    logic                   redir_q;
    logic                   rst_q = 1'b0;
    frontend_pkg::dec_pkt_t hold_pkt;
    int                     errors = 0;
    int                     cycles = 0;

    frontend_top frontend_top_inst (
        .clk            (clk),
        .rst            (rst),
        .imem_addr      (imem_addr),
        .imem_data      (imem_data),
        .dec_valid      (dec_valid),
        .dec_ready      (dec_ready),
        .dec_pkt        (dec_pkt),
        .redirect_valid (redirect_valid)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Program image
    ////////////////////////////////////////////////////////////////////////////

    // addi.w r1, r1, imm
    function automatic isa_pkg::inst_t alu_word(logic [11:0] imm);
        return {10'b0000001010, imm, 5'd1, 5'd1};
    endfunction

    // Compare branches and jirl with a word offset
    function automatic isa_pkg::inst_t off16_word(isa_pkg::opcode_t op, logic [15:0] offs);
        return {op, offs, 5'd1, 5'd2};
    endfunction

    // b and bl with the low offset half first
    function automatic isa_pkg::inst_t off26_word(isa_pkg::opcode_t op, logic [25:0] offs);
        return {op, offs[15:0], offs[25:16]};
    endfunction

    function automatic isa_pkg::inst_t program_word(isa_pkg::addr_t addr);
        isa_pkg::addr_t offset;
        offset = addr - `FE_RESET_PC;
        case (offset)
            32'h00: return alu_word(12'd1);
            32'h04: return alu_word(12'd2);
            // Forward beq to 0x10 falls through until trained
            32'h08: return off16_word(isa_pkg::OP_BEQ, 16'd2);
            32'h0c: return alu_word(12'd3);
            // b over 0x14
            32'h10: return off26_word(isa_pkg::OP_B, 26'd2);
            32'h14: return alu_word(12'd99);
            // Call to the stub at 0x30
            32'h18: return off26_word(isa_pkg::OP_BL, 26'd6);
            32'h1c: return alu_word(12'd4);
            // Loop bottom jumps 8 words back to 0x00
            32'h20: return off16_word(isa_pkg::OP_BNE, 16'hfff8);
            32'h30: return alu_word(12'd5);
            // Return 6 words back to 0x1c
            32'h34: return off16_word(isa_pkg::OP_JIRL, 16'hfffa);
            // Filler folds the whole address into the immediate
            default: return alu_word(addr[11:0] ^ addr[23:12] ^ {4'd0, addr[31:24]});
        endcase
    endfunction

    // Instruction word in the same cycle
    assign imem_data = program_word(imem_addr);

    ////////////////////////////////////////////////////////////////////////////
    // Reference decode
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic is_conditional(isa_pkg::inst_t inst);
        case (inst[31:26])
            isa_pkg::OP_BEQ, isa_pkg::OP_BNE, isa_pkg::OP_BLT,
            isa_pkg::OP_BGE, isa_pkg::OP_BLTU, isa_pkg::OP_BGEU: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

    function automatic isa_pkg::br_kind_e decode_kind(isa_pkg::inst_t inst);
        if (is_conditional(inst)) begin
            return isa_pkg::BR_DIRECT;
        end
        case (inst[31:26])
            isa_pkg::OP_B:    return isa_pkg::BR_DIRECT;
            isa_pkg::OP_BL:   return isa_pkg::BR_CALL;
            isa_pkg::OP_JIRL: return isa_pkg::BR_JIRL;
            default:          return isa_pkg::BR_NONE;
        endcase
    endfunction

    // Word offset scaled to bytes
    function automatic isa_pkg::addr_t branch_target(isa_pkg::addr_t pc, isa_pkg::inst_t inst);
        isa_pkg::addr_t offs;
        if (is_conditional(inst) || inst[31:26] == isa_pkg::OP_JIRL) begin
            offs = {{16{inst[25]}}, inst[25:10]};
        end else if (inst[31:26] == isa_pkg::OP_B || inst[31:26] == isa_pkg::OP_BL) begin
            offs = {{6{inst[9]}}, inst[9:0], inst[25:10]};
        end else begin
            offs = 32'd1;
        end
        return pc + (offs << 2);
    endfunction

    function automatic logic [5:0] slot_of(isa_pkg::addr_t pc);
        isa_pkg::addr_t offset;
        offset = pc - `FE_RESET_PC;
        return offset[7:2];
    endfunction

    task automatic clear_predictions();
        int i;
        for (i = 0; i < 64; i++) begin
            pred_table[i] = '0;
        end
    endtask

    // Next expected packet; trains the model table on a misprediction
    task automatic expect_packet(input isa_pkg::addr_t pc);
        isa_pkg::inst_t    inst;
        isa_pkg::br_kind_e kind;
        isa_pkg::addr_t    target;
        isa_pkg::br_kind_e pred_kind;
        isa_pkg::addr_t    pred_npc;
        logic              uncond;
        logic              miss;
        isa_pkg::addr_t    npc;
        pred_entry_t       entry;
        inst   = program_word(pc);
        kind   = decode_kind(inst);
        target = branch_target(pc, inst);
        uncond = (kind != isa_pkg::BR_NONE) && !is_conditional(inst);
        entry  = pred_table[slot_of(pc)];
        pred_kind = entry.valid ? entry.kind : isa_pkg::BR_NONE;
        pred_npc  = entry.valid ? entry.target : pc + 32'd4;
        if (pred_kind != kind) begin
            miss = 1'b1;
        end else if (uncond) begin
            miss = (pred_npc != target);
        end else begin
            miss = (pred_npc != pc + 32'd4) && (pred_npc != target);
        end
        // Static resolution takes a backward conditional
        if (uncond) begin
            npc = target;
        end else if (!miss) begin
            npc = pred_npc;
        end else if (target < pc) begin
            npc = target;
        end else begin
            npc = pc + 32'd4;
        end
        if (miss) begin
            pred_table[slot_of(pc)] = '{valid: (kind != isa_pkg::BR_NONE), kind: kind,
                                        target: target};
        end
        exp_pkt <= '{pc: pc, inst: inst, kind: kind, next_pc: npc};
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Error reporting
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [127:0] got,
                                   input logic [127:0] want);
        errors++;
        $display("mismatch %s: got %0h expected %0h", name, got, want);
    endtask

    task automatic flag_failure(input string what);
        errors++;
        $display("error: %s", what);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Clock, reset and back-pressure
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    initial begin
        void'($urandom(32'h278b_9c9c));
        rst       = 1'b1;
        dec_ready = 1'b0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        while (accepted < PACKETS && cycles < TIMEOUT_CYCLES) begin
            // Ready about 70 percent of cycles
            dec_ready = ($urandom % 100) < READY_PERCENT;
            @(negedge clk);
            cycles++;
        end
        if (accepted < PACKETS) begin
            flag_failure($sformatf("timeout after %0d cycles, %0d of %0d packets decoded",
                                   cycles, accepted, PACKETS));
        end
        $display("errors %0d, packets %0d, redirects %0d, cycles %0d",
                 errors, accepted, redirect_total, cycles);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference path and history
    ////////////////////////////////////////////////////////////////////////////

    // Advance on every accepted packet
    always @(posedge clk) begin
        if (rst) begin
            clear_predictions();
            first_pending <= 1'b1;
            accepted      <= 0;
            expect_packet(`FE_RESET_PC);
        end else if (dec_valid && dec_ready) begin
            first_pending <= 1'b0;
            accepted      <= accepted + 1;
            expect_packet(exp_pkt.next_pc);
        end
    end

    // Redirecting packet sits in the output register one cycle later
    always @(posedge clk) begin
        if (rst) begin
            redir_q <= 1'b0;
        end else begin
            redir_q <= redirect_valid;
            if (redir_q) begin
                redirect_count[slot_of(dec_pkt.pc)] <= redirect_count[slot_of(dec_pkt.pc)] + 1;
                redirect_total <= redirect_total + 1;
            end
        end
    end

    always @(posedge clk) begin
        rst_q    <= rst;
        hold_pkt <= dec_pkt;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    a_reset_quiet: assert property (@(posedge clk) (rst && rst_q) |-> !dec_valid)
        else flag_failure("dec_valid high during reset");

    a_first_pc: assert property (@(posedge clk) disable iff (rst)
        (dec_valid && first_pending) |-> (dec_pkt.pc == `FE_RESET_PC))
        else report_mismatch("dec_pkt.pc", $sampled(dec_pkt.pc), `FE_RESET_PC);

    a_path_pc: assert property (@(posedge clk) disable iff (rst)
        (dec_valid && dec_ready) |-> (dec_pkt.pc == exp_pkt.pc))
        else report_mismatch("dec_pkt.pc", $sampled(dec_pkt.pc), $sampled(exp_pkt.pc));

    a_path_npc: assert property (@(posedge clk) disable iff (rst)
        (dec_valid && dec_ready) |-> (dec_pkt.next_pc == exp_pkt.next_pc))
        else report_mismatch("dec_pkt.next_pc", $sampled(dec_pkt.next_pc),
                             $sampled(exp_pkt.next_pc));

    a_inst: assert property (@(posedge clk) disable iff (rst)
        (dec_valid && dec_ready) |-> (dec_pkt.inst == exp_pkt.inst))
        else report_mismatch("dec_pkt.inst", $sampled(dec_pkt.inst), $sampled(exp_pkt.inst));

    a_kind: assert property (@(posedge clk) disable iff (rst)
        (dec_valid && dec_ready) |-> (dec_pkt.kind == exp_pkt.kind))
        else report_mismatch("dec_pkt.kind", $sampled(dec_pkt.kind), $sampled(exp_pkt.kind));

    // Stalled output holds still
    a_hold: assert property (@(posedge clk) disable iff (rst)
        (dec_valid && !dec_ready) |=> (dec_valid && dec_pkt == hold_pkt))
        else report_mismatch("dec_pkt", $sampled(dec_pkt), $sampled(hold_pkt));

    // One training redirect per branch
    a_train_once: assert property (@(posedge clk) disable iff (rst)
        redir_q |-> (dec_valid && redirect_count[slot_of(dec_pkt.pc)] == 0))
        else flag_failure($sformatf("pc %h redirected the front end again after training",
                                    $sampled(dec_pkt.pc)));

endmodule

// ==== hw/frontend_top.sv ====
module frontend_top (
    input  logic                   clk,
    input  logic                   rst,
    output isa_pkg::addr_t         imem_addr,
    input  isa_pkg::inst_t         imem_data,
    output logic                   dec_valid,
    input  logic                   dec_ready,
    output frontend_pkg::dec_pkt_t dec_pkt,
    output logic                   redirect_valid
);

    // Generator to queue
    logic                     gen_valid;
    logic                     gen_ready;
    frontend_pkg::fetch_pkt_t gen_pkt;

    // Queue head to pre-decoder
    logic                     head_valid;
    logic                     head_ready;
    frontend_pkg::fetch_pkt_t head_pkt;

    // Correction from the pre-decoder
    frontend_pkg::redirect_t   redirect;
    frontend_pkg::btt_update_t btt_upd;

    fetch_pc_gen fetch_pc_gen_inst (
        .clk       (clk),
        .rst       (rst),
        .imem_addr (imem_addr),
        .imem_data (imem_data),
        .pkt_valid (gen_valid),
        .pkt_ready (gen_ready),
        .pkt       (gen_pkt),
        .redirect  (redirect),
        .btt_upd   (btt_upd)
    );

    // Redirect empties the queue
    fetch_queue fetch_queue_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (gen_valid),
        .in_ready  (gen_ready),
        .in_pkt    (gen_pkt),
        .out_valid (head_valid),
        .out_ready (head_ready),
        .out_pkt   (head_pkt),
        .flush     (redirect.valid)
    );

    if2_predecoder if2_predecoder_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (head_valid),
        .in_ready  (head_ready),
        .in_pkt    (head_pkt),
        .redirect  (redirect),
        .btt_upd   (btt_upd),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_pkt   (dec_pkt)
    );

    // For performance counting
    assign redirect_valid = redirect.valid;

endmodule

// ==== hw/if2_predecoder.sv ====
module if2_predecoder (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      in_valid,
    output logic                      in_ready,
    input  frontend_pkg::fetch_pkt_t  in_pkt,
    output frontend_pkg::redirect_t   redirect,
    output frontend_pkg::btt_update_t btt_upd,
    output logic                      dec_valid,
    input  logic                      dec_ready,
    output frontend_pkg::dec_pkt_t    dec_pkt
);

    isa_pkg::opcode_t  opcode;
    logic              is_cond;
    logic              is_uncond;
    isa_pkg::br_kind_e kind;
    isa_pkg::addr_t    imm;
    isa_pkg::addr_t    target;
    isa_pkg::addr_t    pc_plus4;
    logic              flush;
    isa_pkg::addr_t    resolved_npc;
    logic              pop;

    logic                   dec_valid_q;
    frontend_pkg::dec_pkt_t dec_pkt_q;

    ////////////////////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////////////////////

    assign opcode = in_pkt.inst[31:26];

    always_comb begin
        is_cond   = 1'b0;
        is_uncond = 1'b0;
        kind      = isa_pkg::BR_NONE;
        case (opcode)
            isa_pkg::OP_BEQ, isa_pkg::OP_BNE, isa_pkg::OP_BLT,
            isa_pkg::OP_BGE, isa_pkg::OP_BLTU, isa_pkg::OP_BGEU: begin
                is_cond = 1'b1;
                kind    = isa_pkg::BR_DIRECT;
            end
            isa_pkg::OP_B: begin
                is_uncond = 1'b1;
                kind      = isa_pkg::BR_DIRECT;
            end
            isa_pkg::OP_BL: begin
                is_uncond = 1'b1;
                kind      = isa_pkg::BR_CALL;
            end
            isa_pkg::OP_JIRL: begin
                is_uncond = 1'b1;
                kind      = isa_pkg::BR_JIRL;
            end
            default: begin
                kind = isa_pkg::BR_NONE;
            end
        endcase
    end

    // 16-bit offset for compare branches and jirl
    // Split 26-bit offset for b and bl, high part in bits 9..0
    always_comb begin
        if (is_cond || opcode == isa_pkg::OP_JIRL) begin
            imm = {{14{in_pkt.inst[25]}}, in_pkt.inst[25:10], 2'b00};
        end else if (opcode == isa_pkg::OP_B || opcode == isa_pkg::OP_BL) begin
            imm = {{4{in_pkt.inst[9]}}, in_pkt.inst[9:0], in_pkt.inst[25:10], 2'b00};
        end else begin
            imm = 32'd4;
        end
    end

    assign target   = in_pkt.pc + imm;
    assign pc_plus4 = in_pkt.pc + 32'd4;

    ////////////////////////////////////////////////////////////////////////////
    // Prediction check
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        if (in_pkt.pred_kind != kind) begin
            flush = 1'b1;
        end else if (is_uncond) begin
            flush = (in_pkt.pred_npc != target);
        end else begin
            // Either fall-through or target is acceptable here
            flush = (in_pkt.pred_npc != pc_plus4) && (in_pkt.pred_npc != target);
        end
    end

    // Static rule, backward conditional counts as taken
    always_comb begin
        if (is_uncond) begin
            resolved_npc = target;
        end else if (!flush) begin
            resolved_npc = in_pkt.pred_npc;
        end else if (target < in_pkt.pc) begin
            resolved_npc = target;
        end else begin
            resolved_npc = pc_plus4;
        end
    end

    // Pop when the output slot is free or draining
    assign in_ready = !dec_valid_q || dec_ready;
    assign pop      = in_valid && in_ready;

    // Correction only on a popped head
    assign redirect.valid  = pop && flush;
    assign redirect.target = resolved_npc;

    assign btt_upd.valid  = pop && flush;
    assign btt_upd.pc     = in_pkt.pc;
    assign btt_upd.kind   = kind;
    assign btt_upd.target = target;

    ////////////////////////////////////////////////////////////////////////////
    // Output register
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            dec_valid_q <= 1'b0;
        end else if (in_ready) begin
            dec_valid_q <= in_valid;
        end
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        if (pop) begin
            dec_pkt_q <= '{pc: in_pkt.pc, inst: in_pkt.inst, kind: kind,
                           next_pc: resolved_npc};
        end
    end

    assign dec_valid = dec_valid_q;
    assign dec_pkt   = dec_pkt_q;

    // Redirected packet lands in the output register next cycle
    a_redirect_pops: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |=> (dec_valid && dec_pkt.next_pc == $past(redirect.target)));

endmodule

// ==== hw/fetch_queue.sv ====
`include "frontend_settings.svh"

module fetch_queue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     in_valid,
    output logic                     in_ready,
    input  frontend_pkg::fetch_pkt_t in_pkt,
    output logic                     out_valid,
    input  logic                     out_ready,
    output frontend_pkg::fetch_pkt_t out_pkt,
    input  logic                     flush
);

    localparam int DEPTH = `FE_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    // Slot index plus wrap bit
    typedef logic [PTR_W:0] ptr_t;

    frontend_pkg::fetch_pkt_t mem [DEPTH];

    ptr_t wr_ptr;
    ptr_t rd_ptr;
    logic full;
    logic empty;
    logic push;
    logic pop;

    ////////////////////////////////////////////////////////////////////////////
    // Status
    ////////////////////////////////////////////////////////////////////////////

    // Same slot, different lap
    assign full  = (wr_ptr[PTR_W] != rd_ptr[PTR_W]) &&
                   (wr_ptr[PTR_W-1:0] == rd_ptr[PTR_W-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign in_ready  = !full;
    assign out_valid = !empty;
    // Show-ahead head
    assign out_pkt   = mem[rd_ptr[PTR_W-1:0]];

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    ////////////////////////////////////////////////////////////////////////////
    // Pointers and storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            // Flush also discards this cycle's write
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
        end
    end

    // Slots, no reset
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr[PTR_W-1:0]] <= in_pkt;
        end
    end

    // Full queue never takes a write
    a_no_write_full: assert property (@(posedge clk) disable iff (rst)
        (full && !flush) |=> (wr_ptr == $past(wr_ptr)));

    // Empty queue never pops
    a_no_pop_empty: assert property (@(posedge clk) disable iff (rst)
        (empty && !flush) |=> (rd_ptr == $past(rd_ptr)));

endmodule

// ==== hw/fetch_pc_gen.sv ====
`include "frontend_settings.svh"

module fetch_pc_gen (
    input  logic                      clk,
    input  logic                      rst,
    output isa_pkg::addr_t            imem_addr,
    input  isa_pkg::inst_t            imem_data,
    output logic                      pkt_valid,
    input  logic                      pkt_ready,
    output frontend_pkg::fetch_pkt_t  pkt,
    input  frontend_pkg::redirect_t   redirect,
    input  frontend_pkg::btt_update_t btt_upd
);

    isa_pkg::addr_t    pc_q;
    logic              btt_hit;
    isa_pkg::br_kind_e btt_kind;
    isa_pkg::addr_t    btt_target;
    logic              pred_taken;

    // Prediction lookup on the current fetch pc
    branch_target_table btt_inst (
        .clk       (clk),
        .rst       (rst),
        .rd_pc     (pc_q),
        .rd_hit    (btt_hit),
        .rd_kind   (btt_kind),
        .rd_target (btt_target),
        .upd       (btt_upd)
    );

    // Instruction returns in the same cycle
    assign imem_addr = pc_q;
    // Offers a packet in every cycle out of reset
    assign pkt_valid = !rst;

    assign pred_taken = btt_hit && (btt_kind != isa_pkg::BR_NONE);

    always_comb begin
        pkt.pc        = pc_q;
        pkt.inst      = imem_data;
        // Fall through when the table has nothing
        pkt.pred_kind = pred_taken ? btt_kind : isa_pkg::BR_NONE;
        pkt.pred_npc  = pred_taken ? btt_target : pc_q + 32'd4;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc_q <= `FE_RESET_PC;
        end else begin
            // Redirect wins and the queue flush drops the offered packet
            if (redirect.valid) begin
                pc_q <= redirect.target;
            end else if (pkt_valid && pkt_ready) begin
                pc_q <= pkt.pred_npc;
            end
        end
    end

    // Table targets and redirects keep the pc on word boundaries
    a_pc_aligned: assert property (@(posedge clk) disable iff (rst)
        pc_q[1:0] == 2'b00);

endmodule

// ==== hw/branch_target_table.sv ====
`include "frontend_settings.svh"

module branch_target_table (
    input  logic                      clk,
    input  logic                      rst,
    input  isa_pkg::addr_t            rd_pc,
    output logic                      rd_hit,
    output isa_pkg::br_kind_e         rd_kind,
    output isa_pkg::addr_t            rd_target,
    input  frontend_pkg::btt_update_t upd
);

    localparam int ENTRIES = `FE_BTT_ENTRIES;
    localparam int IDX_W   = $clog2(ENTRIES);
    // Word address bits left over after the index
    localparam int TAG_W   = 30 - IDX_W;

    typedef logic [IDX_W-1:0] idx_t;
    typedef logic [TAG_W-1:0] tag_t;

    // Stored payload of one entry
    typedef struct packed {
        tag_t              tag;
        isa_pkg::br_kind_e kind;
        isa_pkg::addr_t    target;
    } entry_t;

    logic [ENTRIES-1:0] valid_q;
    entry_t             mem [ENTRIES];

    idx_t rd_idx;
    tag_t rd_tag;
    idx_t wr_idx;
    tag_t wr_tag;

    // Index skips the byte offset bits
    assign rd_idx = rd_pc[IDX_W+1:2];
    assign rd_tag = rd_pc[31:IDX_W+2];
    assign wr_idx = upd.pc[IDX_W+1:2];
    assign wr_tag = upd.pc[31:IDX_W+2];

    // Same-cycle lookup
    assign rd_hit    = valid_q[rd_idx] && (mem[rd_idx].tag == rd_tag);
    assign rd_kind   = mem[rd_idx].kind;
    assign rd_target = mem[rd_idx].target;

    // Valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= '0;
        end else if (upd.valid) begin
            // A non-branch write drops the entry
            valid_q[wr_idx] <= (upd.kind != isa_pkg::BR_NONE);
        end
    end

    // Payload, no reset
    always_ff @(posedge clk) begin
        if (upd.valid) begin
            mem[wr_idx] <= '{tag: wr_tag, kind: upd.kind, target: upd.target};
        end
    end

endmodule

// ==== hw/frontend_pkg.sv ====
package frontend_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Packets between stages
    ////////////////////////////////////////////////////////////////////////////

    // Fetched word plus its prediction, 98 bits
    typedef struct packed {
        isa_pkg::addr_t    pc;
        isa_pkg::inst_t    inst;
        isa_pkg::br_kind_e pred_kind;
        isa_pkg::addr_t    pred_npc;
    } fetch_pkt_t;

    // Pre-decoded word with checked next pc
    typedef struct packed {
        isa_pkg::addr_t    pc;
        isa_pkg::inst_t    inst;
        isa_pkg::br_kind_e kind;
        isa_pkg::addr_t    next_pc;
    } dec_pkt_t;

    ////////////////////////////////////////////////////////////////////////////
    // Correction paths
    ////////////////////////////////////////////////////////////////////////////

    // Front end restart
    typedef struct packed {
        logic           valid;
        isa_pkg::addr_t target;
    } redirect_t;

    // Table training write
    // Kind BR_NONE drops the entry
    typedef struct packed {
        logic              valid;
        isa_pkg::addr_t    pc;
        isa_pkg::br_kind_e kind;
        isa_pkg::addr_t    target;
    } btt_update_t;

endpackage

// ==== hw/isa_pkg.sv ====
package isa_pkg;

    // Raw instruction word
    typedef logic [31:0] inst_t;
    // Byte address
    typedef logic [31:0] addr_t;
    // Major opcode, bits 31..26
    typedef logic [5:0] opcode_t;

    ////////////////////////////////////////////////////////////////////////////
    // Branch opcodes
    ////////////////////////////////////////////////////////////////////////////

    localparam opcode_t OP_JIRL = 6'h13;
    localparam opcode_t OP_B    = 6'h14;
    localparam opcode_t OP_BL   = 6'h15;
    // Conditional compare branches
    localparam opcode_t OP_BEQ  = 6'h16;
    localparam opcode_t OP_BNE  = 6'h17;
    localparam opcode_t OP_BLT  = 6'h18;
    localparam opcode_t OP_BGE  = 6'h19;
    localparam opcode_t OP_BLTU = 6'h1a;
    localparam opcode_t OP_BGEU = 6'h1b;

    // Branch kind as stored in the table
    // Direct covers b and all conditional branches
    typedef enum logic [1:0] {
        BR_NONE   = 2'd0,
        BR_DIRECT = 2'd1,
        BR_CALL   = 2'd2,
        BR_JIRL   = 2'd3
    } br_kind_e;

endpackage

// ==== hw/frontend_settings.svh ====
`ifndef FRONTEND_SETTINGS_SVH
`define FRONTEND_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Front end sizing
////////////////////////////////////////////////////////////////////////////

// Branch target table entries, power of two
`define FE_BTT_ENTRIES 16

// Fetch queue slots, power of two and at least 2
`define FE_QUEUE_DEPTH 4

////////////////////////////////////////////////////////////////////////////
// Boot
////////////////////////////////////////////////////////////////////////////

// First fetch address after reset
`define FE_RESET_PC 32'h1c00_0000

`endif
